// ==== source/gem_tx_pkg.sv ====
package gem_tx_pkg;

   //--------------------------------------------------------------------------
   // Link geometry
   //--------------------------------------------------------------------------

   localparam int N_LINKS        = 4;                      // Trigger links per board
   localparam int FRAME_MULT     = 4;                      // Clocks per slot, one word each
   localparam int LINK_PAYLOAD_W = 56;                     // Cluster bits per link
   localparam int GEM_DATA_W     = 2 * LINK_PAYLOAD_W;     // Even links low half, odd high
   localparam int SLOT_CNT_W     = $clog2(FRAME_MULT + 1); // Room above the last slot
   localparam logic [SLOT_CNT_W-1:0] SLOT_LAST = SLOT_CNT_W'(FRAME_MULT - 1);

   //--------------------------------------------------------------------------
   // Startup timing, in clock_40 cycles
   //--------------------------------------------------------------------------

   localparam int STARTUP_CNT_W = 10;
   localparam logic [STARTUP_CNT_W-1:0] STARTUP_CNT_MAX = 10'd1023; // Saturation point

   // Per-link transceiver reset hold, link 3 down to link 0
   localparam logic [N_LINKS-1:0][STARTUP_CNT_W-1:0] MGT_RESET_CNT =
      {10'd140, 10'd120, 10'd80, 10'd40};

   localparam logic [STARTUP_CNT_W-1:0] GTXTEST_START_CNT = 10'd160; // Divider reset kick
   localparam logic [STARTUP_CNT_W-1:0] TXRESET_CNT       = 10'd180; // PCS reset pulse
   localparam logic [STARTUP_CNT_W-1:0] DONE_CNT          = 10'd300; // Done strictly above

   // Divider reset windows, both edges exclusive
   localparam int GTXTEST_CNT_W = 6;
   localparam logic [GTXTEST_CNT_W-1:0] GTXTEST_CNT_MAX = 6'd63;
   localparam logic [GTXTEST_CNT_W-1:0] GTXTEST_WIN0_LO = 6'd0;
   localparam logic [GTXTEST_CNT_W-1:0] GTXTEST_WIN0_HI = 6'd16;
   localparam logic [GTXTEST_CNT_W-1:0] GTXTEST_WIN1_LO = 6'd31;
   localparam logic [GTXTEST_CNT_W-1:0] GTXTEST_WIN1_HI = 6'd48;

   localparam int READY_CNT_W = 8;
   localparam logic [READY_CNT_W-1:0] READY_CNT_MAX = 8'd255; // Links stable this long

   //--------------------------------------------------------------------------
   // 8b10b control characters
   //--------------------------------------------------------------------------

   localparam logic [15:0] K_IDLE_WORD = 16'hFFFC; // K28.7 idle while link is down
   localparam logic [1:0]  ISK_COMMA   = 2'b01;    // K flag on the low byte only
   localparam logic [1:0]  ISK_DATA    = 2'b00;

   localparam logic [7:0] K_BC0      = 8'hBC; // K28.5
   localparam logic [7:0] K_RESYNC   = 8'h3C; // K28.1
   localparam logic [7:0] K_OVERFLOW = 8'hFE; // K30.7

   // Bunch sequence markers, indexed by BX LSBs (K28.0, K23.7, K27.7, K29.7)
   localparam logic [3:0][7:0] K_SEQ = {8'hFD, 8'hFB, 8'hF7, 8'h1C};

   //--------------------------------------------------------------------------
   // Types
   //--------------------------------------------------------------------------

   typedef struct packed {
      logic [GEM_DATA_W-1:0] data;     // Cluster word for both link halves
      logic                  bc0;
      logic                  resync;
      logic                  overflow; // More than 8 clusters
      logic [1:0]            bxn_lsbs;
   } gem_frame_in_t;

   // First word of a frame: payload byte 0 over the separator
   typedef struct packed {
      logic [7:0] data_byte;
      logic [7:0] sep_char;
   } comma_word_t;

   typedef union packed {
      logic [15:0] raw;   // Payload words and idle
      comma_word_t comma;
   } tx_word_u;

   typedef struct packed {
      tx_word_u   word;
      logic [1:0] isk;
   } link_tx_t;

   typedef struct packed {
      logic [N_LINKS-1:0] mgt_reset;
      logic               txreset;
      logic               gtxtest_reset; // GTXTEST[1], TX output divider reset
   } mgt_ctrl_t;

endpackage

// ==== source/startup_sequencer.sv ====
`timescale 1ns/10ps

module startup_sequencer (
   input  logic                           clock_40,
   input  logic                           rst_n_i,
   input  logic [gem_tx_pkg::N_LINKS-1:0] mgt_reset_i,     // Manual link resets
   input  logic                           txreset_i,       // Manual PCS reset
   input  logic                           gtxtest_start_i, // Manual divider reset start
   output logic [gem_tx_pkg::N_LINKS-1:0] mgt_reset_o,
   output logic                           txreset_o,
   output logic                           gtxtest_start_o,
   output logic                           startup_done_o
);

   import gem_tx_pkg::*;

   logic [STARTUP_CNT_W-1:0] startup_cnt; // Cycles since reset release
   logic                     txreset_seq; // Counter-timed PCS reset

   //--------------------------------------------------------------------------
   // Startup counter
   //--------------------------------------------------------------------------

   always_ff @(posedge clock_40) begin
      if (!rst_n_i) begin
         startup_cnt <= '0;
      end else if (startup_cnt < STARTUP_CNT_MAX) begin
         startup_cnt <= startup_cnt + 1'b1;
      end
   end

   //--------------------------------------------------------------------------
   // Decoded controls, each ORed with its override
   //--------------------------------------------------------------------------

   // Links come out of reset one after another
   for (genvar i = 0; i < N_LINKS; i++) begin : g_mgt_reset
      assign mgt_reset_o[i] = mgt_reset_i[i] | (startup_cnt < MGT_RESET_CNT[i]);
   end

   assign txreset_seq     = (startup_cnt == TXRESET_CNT);     // Single cycle
   assign txreset_o       = txreset_i | txreset_seq;
   assign gtxtest_start_o = gtxtest_start_i | (startup_cnt == GTXTEST_START_CNT);

   // No override here, done only follows the count
   assign startup_done_o = (startup_cnt > DONE_CNT);

   //--------------------------------------------------------------------------
   // Checks
   //--------------------------------------------------------------------------

   // Steps by one or holds at the limit, never wraps back to the reset window
   a_cnt_saturates : assert property (@(posedge clock_40)
      rst_n_i |=> (startup_cnt == $past(startup_cnt) + 1'b1) ||
                  (startup_cnt == STARTUP_CNT_MAX))
      else $error("startup counter left its saturating range");

   // The timed txreset is a true pulse at the output
   a_txreset_pulse : assert property (@(posedge clock_40)
      (txreset_o && !txreset_i) |=> !(txreset_o && !txreset_i))
      else $error("txreset held for two cycles without override");

endmodule

// ==== source/gtxtest_pulse.sv ====
`timescale 1ns/10ps

module gtxtest_pulse (
   input  logic clock_40,
   input  logic rst_n_i,
   input  logic gtxtest_start_i, // One-cycle start, restarts the sequence
   output logic gtxtest_reset_o  // TX output divider reset
);

   import gem_tx_pkg::*;

   logic [GTXTEST_CNT_W-1:0] gtxtest_cnt;

   // Parked at the limit so nothing fires until the first start
   always_ff @(posedge clock_40) begin
      if (!rst_n_i) begin
         gtxtest_cnt <= GTXTEST_CNT_MAX;
      end else if (gtxtest_start_i) begin
         gtxtest_cnt <= '0;                  // Restart even mid-sequence
      end else if (gtxtest_cnt < GTXTEST_CNT_MAX) begin
         gtxtest_cnt <= gtxtest_cnt + 1'b1;
      end
   end

   // Two reset windows with a gap between them
   assign gtxtest_reset_o =
      ((gtxtest_cnt > GTXTEST_WIN0_LO) && (gtxtest_cnt < GTXTEST_WIN0_HI)) ||
      ((gtxtest_cnt > GTXTEST_WIN1_LO) && (gtxtest_cnt < GTXTEST_WIN1_HI));

   // Idle counter means dividers run free
   a_idle_quiet : assert property (@(posedge clock_40)
      (gtxtest_cnt == GTXTEST_CNT_MAX) |-> !gtxtest_reset_o)
      else $error("gtxtest reset high with counter saturated");

endmodule

// ==== source/link_ready_monitor.sv ====
`timescale 1ns/10ps

module link_ready_monitor (
   input  logic                           clock_40,
   input  logic                           rst_n_i,
   input  logic [gem_tx_pkg::N_LINKS-1:0] tx_done_i,         // Per-link reset done
   input  logic                           force_not_ready_i,
   output logic                           link_up_o,
   output logic                           ready_o
);

   import gem_tx_pkg::*;

   logic                   all_done;  // Every transceiver finished reset
   logic [READY_CNT_W-1:0] ready_cnt; // Time the links have been stable

   assign all_done = &tx_done_i;

   //--------------------------------------------------------------------------
   // Link status and ready flag
   //--------------------------------------------------------------------------

   // Both flags sample the same done level, ready never leads link_up
   always_ff @(posedge clock_40) begin
      if (!rst_n_i) begin
         link_up_o <= 1'b0;
         ready_o   <= 1'b0;
      end else begin
         link_up_o <= all_done;
         ready_o   <= all_done && !force_not_ready_i && (ready_cnt == READY_CNT_MAX);
      end
   end

   //--------------------------------------------------------------------------
   // Ready timer
   //--------------------------------------------------------------------------

   always_ff @(posedge clock_40) begin
      if (!rst_n_i || !link_up_o || force_not_ready_i) begin
         ready_cnt <= '0;                      // Any glitch restarts the wait
      end else if (ready_cnt < READY_CNT_MAX) begin
         ready_cnt <= ready_cnt + 1'b1;
      end
   end

   a_ready_needs_link : assert property (@(posedge clock_40)
      ready_o |-> link_up_o)
      else $error("ready asserted while links are down");

endmodule

// ==== source/trigger_framer.sv ====
`timescale 1ns/10ps

module trigger_framer (
   input  logic                                           clock_40,
   input  logic                                           rst_n_i,
   input  logic                                           link_up_i,
   input  gem_tx_pkg::gem_frame_in_t                      frame_i,   // Sampled once per slot
   output gem_tx_pkg::link_tx_t [gem_tx_pkg::N_LINKS-1:0] link_tx_o
);

   import gem_tx_pkg::*;

   logic [SLOT_CNT_W-1:0] slot_cnt; // Word index within the frame
   gem_frame_in_t         frame_q;  // Payload of the frame being sent
   logic [7:0]            sep_char; // Frame separator K-character

   //--------------------------------------------------------------------------
   // Frame slot counter
   //--------------------------------------------------------------------------

   always_ff @(posedge clock_40) begin
      if (!rst_n_i || !link_up_i) begin
         slot_cnt <= '0;                      // Next frame starts at word 0
      end else if (slot_cnt == SLOT_LAST) begin
         slot_cnt <= '0;
      end else begin
         slot_cnt <= slot_cnt + 1'b1;
      end
   end

   //--------------------------------------------------------------------------
   // Capture
   //--------------------------------------------------------------------------

   // Loads on the last word, so word 0 of the next frame sees fresh data
   always_ff @(posedge clock_40) begin
      if (!rst_n_i || !link_up_i || (slot_cnt == SLOT_LAST)) begin
         frame_q <= frame_i;
      end
   end

   //--------------------------------------------------------------------------
   // Separator choice
   //--------------------------------------------------------------------------

   always_comb begin
      if (frame_q.bc0) begin
         sep_char = K_BC0;                    // Orbit marker wins
      end else if (frame_q.resync) begin
         sep_char = K_RESYNC;
      end else if (frame_q.overflow) begin
         sep_char = K_OVERFLOW;
      end else begin
         sep_char = K_SEQ[frame_q.bxn_lsbs];  // Plain bunch sequence marker
      end
   end

   //--------------------------------------------------------------------------
   // Per-link word mux and output register
   //--------------------------------------------------------------------------

   for (genvar i = 0; i < N_LINKS; i++) begin : g_link
      logic [LINK_PAYLOAD_W-1:0] link_data; // This link's half of the clusters
      tx_word_u                  word_d;
      logic [1:0]                isk_d;
      link_tx_t                  tx_q;

      // Even links take the low half, odd links the high half
      assign link_data = frame_q.data[(i % 2) * LINK_PAYLOAD_W +: LINK_PAYLOAD_W];

      always_comb begin
         word_d.raw = K_IDLE_WORD;            // Out-of-range slot
         isk_d      = ISK_COMMA;
         case (slot_cnt)
            SLOT_CNT_W'(0): begin
               word_d.comma.data_byte = link_data[7:0];
               word_d.comma.sep_char  = sep_char;
               isk_d                  = ISK_COMMA;
            end
            SLOT_CNT_W'(1): begin
               word_d.raw = link_data[23:8];
               isk_d      = ISK_DATA;
            end
            SLOT_CNT_W'(2): begin
               word_d.raw = link_data[39:24];
               isk_d      = ISK_DATA;
            end
            SLOT_CNT_W'(3): begin
               word_d.raw = link_data[55:40];
               isk_d      = ISK_DATA;
            end
            default: begin
               word_d.raw = K_IDLE_WORD;
               isk_d      = ISK_COMMA;
            end
         endcase
      end

      always_ff @(posedge clock_40) begin
         if (!rst_n_i || !link_up_i) begin
            tx_q.word.raw <= K_IDLE_WORD;    // Keeps the receiver aligned
            tx_q.isk      <= ISK_COMMA;
         end else begin
            tx_q.word <= word_d;
            tx_q.isk  <= isk_d;
         end
      end

      assign link_tx_o[i] = tx_q;
   end

   a_slot_range : assert property (@(posedge clock_40)
      slot_cnt <= SLOT_LAST)
      else $error("frame slot counter beyond last word");

endmodule

// ==== source/gem_link_tx_top.sv ====
`timescale 1ns/10ps

module gem_link_tx_top (
   input  logic                                           clock_40,
   input  logic                                           rst_n_i,
   input  gem_tx_pkg::gem_frame_in_t                      frame_i,
   input  logic [gem_tx_pkg::N_LINKS-1:0]                 tx_done_i,
   input  logic                                           force_not_ready_i,
   input  logic [gem_tx_pkg::N_LINKS-1:0]                 mgt_reset_i,
   input  logic                                           txreset_i,
   input  logic                                           gtxtest_start_i,
   output gem_tx_pkg::link_tx_t [gem_tx_pkg::N_LINKS-1:0] link_tx_o,
   output gem_tx_pkg::mgt_ctrl_t                          mgt_ctrl_o,
   output logic                                           startup_done_o,
   output logic                                           ready_o
);

   import gem_tx_pkg::*;

   //--------------------------------------------------------------------------
   // Internal wires
   //--------------------------------------------------------------------------

   logic [N_LINKS-1:0] mgt_reset;     // Staggered transceiver resets
   logic               txreset;       // One-cycle PCS reset
   logic               gtxtest_start; // Kicks the divider reset windows
   logic               gtxtest_reset;
   logic               link_up;       // All transceivers report done

   // Transceiver control bundle
   assign mgt_ctrl_o.mgt_reset     = mgt_reset;
   assign mgt_ctrl_o.txreset       = txreset;
   assign mgt_ctrl_o.gtxtest_reset = gtxtest_reset;

   //--------------------------------------------------------------------------
   // Startup and transceiver control
   //--------------------------------------------------------------------------

   startup_sequencer u_startup_sequencer (
      .clock_40        (clock_40),
      .rst_n_i         (rst_n_i),
      .mgt_reset_i     (mgt_reset_i),
      .txreset_i       (txreset_i),
      .gtxtest_start_i (gtxtest_start_i),
      .mgt_reset_o     (mgt_reset),
      .txreset_o       (txreset),
      .gtxtest_start_o (gtxtest_start),
      .startup_done_o  (startup_done_o)
   );

   gtxtest_pulse u_gtxtest_pulse (
      .clock_40        (clock_40),
      .rst_n_i         (rst_n_i),
      .gtxtest_start_i (gtxtest_start),
      .gtxtest_reset_o (gtxtest_reset)
   );

   link_ready_monitor u_link_ready_monitor (
      .clock_40          (clock_40),
      .rst_n_i           (rst_n_i),
      .tx_done_i         (tx_done_i),
      .force_not_ready_i (force_not_ready_i),
      .link_up_o         (link_up),
      .ready_o           (ready_o)
   );

   //--------------------------------------------------------------------------
   // Trigger data path
   //--------------------------------------------------------------------------

   trigger_framer u_trigger_framer (
      .clock_40  (clock_40),
      .rst_n_i   (rst_n_i),
      .link_up_i (link_up),    // Idle words until the links are up
      .frame_i   (frame_i),
      .link_tx_o (link_tx_o)
   );

endmodule

// ==== bench/gem_link_tx_tb.sv ====
`timescale 1ns/10ps

module gem_link_tx_tb;

   import gem_tx_pkg::*;

   localparam int unsigned SEED  = 32'h0d1fdcf7;
   localparam int RESET_CYC      = 16;
   localparam int PH_STARTUP     = 400;                        // Past DONE_CNT
   localparam int PH_OVR         = 200;                        // Random override pulses
   localparam int READY_WAIT     = int'(READY_CNT_MAX) + 10;   // Bound on the ready rise
   localparam int N_ROUNDS       = 4;
   localparam int ROUND_LEN      = 300;                        // Long enough to regain ready
   localparam int TIMEOUT_CYC    = RESET_CYC + PH_STARTUP + PH_OVR + READY_WAIT + 1 +
                                   N_ROUNDS * ROUND_LEN + 100;
   localparam logic [17:0] IDLE_TX = {K_IDLE_WORD, 2'b01};

   logic                     clock_40;
   logic                     rst_n_i;
   gem_frame_in_t            frame_i;
   logic [N_LINKS-1:0]       tx_done_i;
   logic                     force_not_ready_i;
   logic [N_LINKS-1:0]       mgt_reset_i;
   logic                     txreset_i;
   logic                     gtxtest_start_i;
   logic [N_LINKS-1:0][17:0] link_tx;      // Word over isk for each link
   mgt_ctrl_t                mgt_ctrl;
   logic                     startup_done;
   logic                     ready;

   // Reference model state
   logic [STARTUP_CNT_W-1:0] m_scnt;
   logic [GTXTEST_CNT_W-1:0] m_gcnt;
   logic                     m_link_up;
   logic [READY_CNT_W-1:0]   m_rtimer;
   logic                     m_ready;
   logic [1:0]               m_slot;
   gem_frame_in_t            m_cap;        // Frame as sampled at the capture edge
   logic [N_LINKS-1:0][17:0] m_tx;
   logic [6:0]               sep_seen;     // BC0, resync, overflow and four BX markers
   int                       cyc = 0;

   gem_link_tx_top DUT (
      .clock_40          (clock_40),
      .rst_n_i           (rst_n_i),
      .frame_i           (frame_i),
      .tx_done_i         (tx_done_i),
      .force_not_ready_i (force_not_ready_i),
      .mgt_reset_i       (mgt_reset_i),
      .txreset_i         (txreset_i),
      .gtxtest_start_i   (gtxtest_start_i),
      .link_tx_o         (link_tx),
      .mgt_ctrl_o        (mgt_ctrl),
      .startup_done_o    (startup_done),
      .ready_o           (ready)
   );

   initial begin
      clock_40 = 1'b0;
      forever #2 clock_40 = ~clock_40;     // 4 ns period
   end

   // ------------------------------------------------------------------------
   // Model helpers
   // ------------------------------------------------------------------------

   // Reset high for counts 1..15 and 32..47 after a start
   function automatic logic in_window(input logic [GTXTEST_CNT_W-1:0] c);
      return ((c >= 6'd1) && (c <= 6'd15)) || ((c >= 6'd32) && (c <= 6'd47));
   endfunction

   function automatic logic [2:0] sep_class(input gem_frame_in_t f);
      if (f.bc0) return 3'd0;
      else if (f.resync) return 3'd1;
      else if (f.overflow) return 3'd2;
      else return 3'd3 + {1'b0, f.bxn_lsbs};
   endfunction

   function automatic logic [17:0] frame_word(input gem_frame_in_t f, input int link,
                                              input logic [1:0] slot);
      logic [LINK_PAYLOAD_W-1:0] half;
      logic [7:0]                sep;
      half = (link % 2 == 1) ? f.data[GEM_DATA_W-1:LINK_PAYLOAD_W] : f.data[LINK_PAYLOAD_W-1:0];
      case (sep_class(f))
         3'd0:    sep = K_BC0;
         3'd1:    sep = K_RESYNC;
         3'd2:    sep = K_OVERFLOW;
         default: sep = K_SEQ[f.bxn_lsbs];
      endcase
      case (slot)
         2'd0:    return {half[7:0], sep, 2'b01};   // Comma word with the K flag on the low byte
         2'd1:    return {half[23:8], 2'b00};
         2'd2:    return {half[39:24], 2'b00};
         default: return {half[55:40], 2'b00};
      endcase
   endfunction

   function automatic gem_frame_in_t random_frame();
      gem_frame_in_t f;
      f.data     = {16'($urandom), $urandom, $urandom, $urandom};
      f.bc0      = ($urandom % 4) == 0;      // Biased so every separator shows up
      f.resync   = ($urandom % 4) == 0;
      f.overflow = ($urandom % 4) == 0;
      f.bxn_lsbs = 2'($urandom);
      return f;
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Fail %0t: %s is %0h, expected %0h", $time, what, got, exp);
         $display("Regression failed");
         $fatal(1, "Mismatch on %s", what);
      end
   endtask

   // ------------------------------------------------------------------------
   // Reference model registers follow the inputs sampled at each edge
   // ------------------------------------------------------------------------

   always @(posedge clock_40) begin
      if (!rst_n_i) begin
         m_scnt    <= '0;
         m_gcnt    <= GTXTEST_CNT_MAX;                 // Parked until the first start
         m_link_up <= 1'b0;
         m_rtimer  <= '0;
         m_ready   <= 1'b0;
         m_slot    <= 2'd0;
         m_cap     <= frame_i;
         sep_seen  <= '0;
         for (int i = 0; i < N_LINKS; i++) begin
            m_tx[i] <= IDLE_TX;
         end
      end else begin
         if (m_scnt < STARTUP_CNT_MAX) begin
            m_scnt <= m_scnt + 1'b1;
         end
         if (gtxtest_start_i || (m_scnt == GTXTEST_START_CNT)) begin
            m_gcnt <= '0;
         end else if (m_gcnt < GTXTEST_CNT_MAX) begin
            m_gcnt <= m_gcnt + 1'b1;
         end
         m_link_up <= &tx_done_i;
         if (!m_link_up || force_not_ready_i) begin
            m_rtimer <= '0;
         end else if (m_rtimer < READY_CNT_MAX) begin
            m_rtimer <= m_rtimer + 1'b1;
         end
         m_ready <= (&tx_done_i) && !force_not_ready_i && (m_rtimer == READY_CNT_MAX);
         if (!m_link_up) begin                         // Idle and capture every cycle
            m_slot <= 2'd0;
            m_cap  <= frame_i;
            for (int i = 0; i < N_LINKS; i++) begin
               m_tx[i] <= IDLE_TX;
            end
         end else begin
            m_slot <= (m_slot == 2'(FRAME_MULT - 1)) ? 2'd0 : m_slot + 2'd1;
            if (m_slot == 2'(FRAME_MULT - 1)) begin
               m_cap <= frame_i;
            end
            if (m_slot == 2'd0) begin
               sep_seen[sep_class(m_cap)] <= 1'b1;
            end
            for (int i = 0; i < N_LINKS; i++) begin
               m_tx[i] <= frame_word(m_cap, i, m_slot);
            end
         end
      end
   end

   // Outputs compared mid-cycle away from the drive edge
   always @(negedge clock_40) begin
      if (cyc > 1) begin
         for (int i = 0; i < N_LINKS; i++) begin
            check_value($sformatf("mgt_reset[%0d]", i), 32'(mgt_ctrl.mgt_reset[i]),
                        32'(mgt_reset_i[i] | (m_scnt < MGT_RESET_CNT[i])));
            check_value($sformatf("link %0d word", i), 32'(link_tx[i]), 32'(m_tx[i]));
         end
         check_value("txreset", 32'(mgt_ctrl.txreset),
                     32'(txreset_i | (m_scnt == TXRESET_CNT)));
         check_value("gtxtest_reset", 32'(mgt_ctrl.gtxtest_reset), 32'(in_window(m_gcnt)));
         check_value("startup_done", 32'(startup_done), 32'(m_scnt > DONE_CNT));
         check_value("ready", 32'(ready), 32'(m_ready));
      end
   end

   always @(posedge clock_40) begin
      if (cyc >= TIMEOUT_CYC) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
         $display("Regression failed");
         $fatal(1, "Timeout");
      end else begin
         cyc <= cyc + 1;
      end
   end

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------

   task automatic next_cycle();
      @(posedge clock_40);
      frame_i <= random_frame();               // Fresh cluster word every cycle
   endtask

   task automatic measure_startup();
      int high_cnt [N_LINKS];
      int tx_cnt;
      int not_done;
      tx_cnt   = 0;
      not_done = 0;
      for (int i = 0; i < N_LINKS; i++) begin
         high_cnt[i] = 0;
      end
      repeat (PH_STARTUP) begin
         @(negedge clock_40);
         for (int i = 0; i < N_LINKS; i++) begin
            if (mgt_ctrl.mgt_reset[i]) high_cnt[i]++;
         end
         if (mgt_ctrl.txreset) tx_cnt++;
         if (!startup_done) not_done++;
         next_cycle();
      end
      for (int i = 0; i < N_LINKS; i++) begin
         check_value($sformatf("mgt_reset[%0d] hold", i), 32'(high_cnt[i]),
                     32'(MGT_RESET_CNT[i]));
      end
      check_value("txreset pulse count", 32'(tx_cnt), 32'd1);
      check_value("startup_done delay", 32'(not_done), 32'(int'(DONE_CNT) + 1));
   endtask

   task automatic pulse_overrides();
      repeat (PH_OVR) begin
         next_cycle();
         mgt_reset_i     <= (($urandom % 8) == 0) ? N_LINKS'($urandom) : '0;
         txreset_i       <= ($urandom % 16) == 0;
         gtxtest_start_i <= ($urandom % 48) == 0;  // Some restart mid-sequence
      end
   endtask

   task automatic time_ready_rise();
      int edges;
      next_cycle();
      mgt_reset_i     <= '0;
      txreset_i       <= 1'b0;
      gtxtest_start_i <= 1'b0;
      tx_done_i       <= '1;
      edges = 0;
      do begin
         next_cycle();
         edges++;
         @(negedge clock_40);
      end while (!ready && (edges < READY_WAIT));
      check_value("ready rise delay", 32'(edges), 32'(int'(READY_CNT_MAX) + 2));
   endtask

   // Short drop of one done bit or a force pulse followed by a stable stretch
   task automatic disturb_link(input int round);
      int   len;
      int   lane;
      logic use_force;
      use_force = (round % 2) == 1;            // Done drops and force pulses take turns
      len       = 1 + int'($urandom % 3);
      lane      = int'($urandom % N_LINKS);
      for (int k = 0; k < len; k++) begin
         next_cycle();
         if (use_force) force_not_ready_i <= 1'b1;
         else tx_done_i <= ~(N_LINKS'(1) << lane);
      end
      next_cycle();
      force_not_ready_i <= 1'b0;
      tx_done_i         <= '1;
      repeat (ROUND_LEN - len - 1) next_cycle();
   endtask

   initial begin
      int unsigned seed_state;
      seed_state        = $urandom(SEED);
      rst_n_i           = 1'b0;
      frame_i           = '0;
      tx_done_i         = '0;
      force_not_ready_i = 1'b0;
      mgt_reset_i       = '0;
      txreset_i         = 1'b0;
      gtxtest_start_i   = 1'b0;
      repeat (RESET_CYC) next_cycle();
      rst_n_i <= 1'b1;
      measure_startup();
      pulse_overrides();
      time_ready_rise();
      for (int r = 0; r < N_ROUNDS; r++) begin
         disturb_link(r);
      end
      @(negedge clock_40);
      assert (sep_seen == 7'h7f) else begin
         $display("Not every separator case was sent, seen mask %b", sep_seen);
      end
      if (sep_seen == 7'h7f) begin
         $display("Regression passed");
         $finish;
      end else begin
         $display("Regression failed");
         $fatal(1, "Separator coverage incomplete");
      end
   end

endmodule

// ==== build.f ====
source/gem_tx_pkg.sv
source/startup_sequencer.sv
source/gtxtest_pulse.sv
source/link_ready_monitor.sv
source/trigger_framer.sv
source/gem_link_tx_top.sv
bench/gem_link_tx_tb.sv

// ==== Makefile ====
TOP := gem_link_tx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir -o Vsim
	./obj_dir/Vsim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Regression failed" sim.log; then \
		echo "Simulation reported a failure, see sim.log"; \
		exit 1; \
	fi
	@grep -q "Regression passed" sim.log || (echo "No pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
